// ==== all.f ====
hdl/lpcPkg.sv
hdl/durbinCoefficientStore.sv
hdl/bestOrderSelector.sv
hdl/lpcOrderController.sv
hdl/lpcCoeffSelect.sv
testbench/lpcCoeffSelectChecks.sv
testbench/lpcCoeffSelectTb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lpcCoeffSelectTb \
    -f all.f -o lpcSim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/lpcSim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || grep -q "Regression passed" sim.log

// ==== testbench/lpcCoeffSelectTb.sv ====
`timescale 1ns/1ns

module lpcCoeffSelectTb;

    localparam int maxOrder      = 12;
    localparam int orderPenalty  = 4;
    localparam int clockPeriod   = 4;
    localparam int ackDelayLimit = 6;
    localparam int wordCount     = 238 + 43; // input words plus output transfers.
    localparam int cyclesPerWord = 8;
    localparam int watchdogLimit = wordCount * cyclesPerWord * (ackDelayLimit + 1) * clockPeriod;

    logic                                 iClock;
    logic                                 reset;
    logic                                 inReq;
    logic                                 inAck;
    lpcPkg::lpcOp                         inOp;
    logic        [lpcPkg::orderWidth-1:0] inOrder;
    logic signed [lpcPkg::coeffWidth-1:0] inCoeff;
    logic        [lpcPkg::errorWidth-1:0] inError;
    logic                                 outReq;
    logic                                 outAck;
    logic signed [lpcPkg::coeffWidth-1:0] outCoeff;
    logic        [lpcPkg::orderWidth-1:0] outIndex;
    logic        [lpcPkg::orderWidth-1:0] outOrder;
    logic                                 outLast;

    // head of the expected transfer list.
    logic signed [lpcPkg::coeffWidth-1:0] expCoeff;
    logic        [lpcPkg::orderWidth-1:0] expIndex;
    logic        [lpcPkg::orderWidth-1:0] expOrder;
    logic                                 expLast;
    int                                   expRemaining;
    int                                   checkErrors;

    int                            logOrder [$]; // words loaded this frame.
    int                            logCoeff [$];
    logic [lpcPkg::errorWidth-1:0] errorModel [1:maxOrder];
    bit                            haveError [1:maxOrder];
    int                            expQ [$];
    int                            frameOrder;
    int                            frameIndex;
    int                            ackDelayMax;
    int                            transferCount;
    int                            testsRun;
    int                            testsFailed;
    int                            errorsBefore;

    lpcCoeffSelect #(.maxOrder(maxOrder), .orderPenalty(orderPenalty)) lpcCoeffSelect_i (.*);

    lpcCoeffSelectChecks lpcCoeffSelectChecks_i (.*);

    initial begin
        iClock = 1'b0;
        forever #(clockPeriod / 2) iClock = ~iClock;
    end

    initial begin
        #(watchdogLimit);
        $display("watchdog expired after %0d ns, the DUT stopped responding", watchdogLimit);
        $display("Regression failed");
        $finish;
    end

    ////////////////////
    // reference model
    ////////////////////

    task automatic showExpected();
        expRemaining = expQ.size();
        expIndex     = lpcPkg::orderWidth'(frameIndex);
        expOrder     = lpcPkg::orderWidth'(frameOrder);
        expLast      = (expQ.size() == 1);
        expCoeff     = (expQ.size() > 0) ? lpcPkg::coeffWidth'(expQ[0]) : '0;
    endtask

    task automatic takeExpected();
        if (expQ.size() > 0) begin
            void'(expQ.pop_front());
        end
        frameIndex++;
        transferCount++;
        showExpected();
    endtask

    task automatic clearModel();
        logOrder.delete();
        logCoeff.delete();
        for (int m = 1; m <= maxOrder; m++) begin
            haveError[m] = 1'b0;
        end
    endtask

    // lowest error plus order times penalty wins.
    function automatic int modelBestOrder();
        longint cost;
        longint bestCost;
        int     best;
        best     = 0;
        bestCost = 0;
        for (int m = 1; m <= maxOrder; m++) begin
            if (haveError[m]) begin
                cost = longint'(errorModel[m]) + longint'(m) * orderPenalty;
                if (cost > 64'hffff_ffff) begin
                    cost = 64'hffff_ffff; // saturates at the error width.
                end
                if (best == 0 || cost < bestCost) begin
                    best     = m;
                    bestCost = cost;
                end
            end
        end
        return best;
    endfunction

    ////////////////////
    // producer side
    ////////////////////

    task automatic sendWord(input lpcPkg::lpcOp op, input int ord,
                            input logic signed [lpcPkg::coeffWidth-1:0] coeffValue,
                            input logic [lpcPkg::errorWidth-1:0] errValue);
        @(negedge iClock);
        inOp    = op;
        inOrder = lpcPkg::orderWidth'(ord);
        inCoeff = coeffValue;
        inError = errValue;
        inReq   = 1'b1;
        while (!inAck) @(negedge iClock);
        inReq = 1'b0;
        while (inAck) @(negedge iClock);
    endtask

    task automatic loadCoeffs(input int ord, input int count);
        logic signed [lpcPkg::coeffWidth-1:0] value;
        for (int i = 0; i < count; i++) begin
            value = lpcPkg::coeffWidth'($urandom);
            logOrder.push_back(ord);
            logCoeff.push_back(int'(value));
            sendWord(lpcPkg::opCoeff, ord, value, '0);
        end
    endtask

    task automatic sendError(input int ord, input logic [lpcPkg::errorWidth-1:0] err);
        errorModel[ord] = err;
        haveError[ord]  = 1'b1;
        sendWord(lpcPkg::opError, ord, '0, err);
    endtask

    // last m coefficients of the winning order in load order.
    task automatic endFrame();
        int best;
        int kept [$];
        best = modelBestOrder();
        expQ.delete();
        if (best != 0) begin
            foreach (logOrder[i]) begin
                if (logOrder[i] == best) begin
                    kept.push_back(logCoeff[i]);
                end
            end
            while (kept.size() > best) void'(kept.pop_front());
            expQ = kept;
        end
        frameOrder = best;
        frameIndex = 0;
        showExpected();
        sendWord(lpcPkg::opFrameEnd, 0, '0, '0);
        clearModel();
    endtask

    task automatic finishTest(input string name);
        repeat (3) @(negedge iClock);
        testsRun++;
        if (checkErrors != errorsBefore) begin
            testsFailed++;
            $display("test %s: FAILED with %0d check errors, %0d transfers", name,
                checkErrors - errorsBefore, transferCount);
        end else begin
            $display("test %s: ok, %0d transfers", name, transferCount);
        end
        errorsBefore  = checkErrors;
        transferCount = 0;
    endtask

    // consumer side with random ack delays.
    initial begin
        outAck = 1'b0;
        forever begin
            @(negedge iClock);
            if (outReq) begin
                repeat ($urandom % (ackDelayMax + 1)) @(negedge iClock);
                outAck = 1'b1;
                @(negedge iClock);
                while (outReq) @(negedge iClock);
                takeExpected();
                repeat ($urandom % (ackDelayMax + 1)) @(negedge iClock);
                outAck = 1'b0;
            end
        end
    end

    initial begin
        void'($urandom(32'hde376f07));
        reset       = 1'b1;
        inReq       = 1'b0;
        inOp        = lpcPkg::opCoeff;
        inOrder     = '0;
        inCoeff     = '0;
        inError     = '0;
        ackDelayMax = 0;
        clearModel();
        showExpected();
        repeat (5) @(posedge iClock);
        @(negedge iClock);
        reset = 1'b0;
        repeat (4) @(negedge iClock);
        finishTest("reset");

        loadCoeffs(5, 5);
        sendError(5, 300);
        endFrame();
        finishTest("single order");

        repeat (2) begin
            for (int m = 1; m <= maxOrder; m++)
                loadCoeffs(m, m);
            for (int m = 1; m <= maxOrder; m++)
                sendError(m, 1000 + $urandom % 64);
            endFrame();
        end
        finishTest("selection");

        loadCoeffs(1, 1);
        for (int m = 1; m <= maxOrder; m++)
            sendError(m, 700); // equal errors.
        endFrame();
        finishTest("tie");

        loadCoeffs(3, 7);
        sendError(3, 50);
        endFrame();
        loadCoeffs(2, 2);
        sendError(2, 50);
        endFrame();
        finishTest("reload");

        ackDelayMax = ackDelayLimit;
        loadCoeffs(8, 8);
        loadCoeffs(4, 4);
        sendError(4, 500);
        sendError(8, 100);
        endFrame();
        ackDelayMax = 0;
        finishTest("back-pressure");

        loadCoeffs(6, 6);
        endFrame();
        finishTest("empty frame");

        $display("tests run %0d, tests failed %0d, check errors %0d", testsRun, testsFailed,
            checkErrors);
        if (testsFailed == 0 && checkErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== testbench/lpcCoeffSelectChecks.sv ====
`timescale 1ns/1ns

module lpcCoeffSelectChecks (
    input  logic                                  iClock,
    input  logic                                  reset,
    input  logic                                  inReq,
    input  logic                                  inAck,
    input  lpcPkg::lpcOp                          inOp,
    input  logic                                  outReq,
    input  logic                                  outAck,
    input  logic signed [lpcPkg::coeffWidth-1:0]  outCoeff,
    input  logic        [lpcPkg::orderWidth-1:0]  outIndex,
    input  logic        [lpcPkg::orderWidth-1:0]  outOrder,
    input  logic                                  outLast,
    input  logic signed [lpcPkg::coeffWidth-1:0]  expCoeff,
    input  logic        [lpcPkg::orderWidth-1:0]  expIndex,
    input  logic        [lpcPkg::orderWidth-1:0]  expOrder,
    input  logic                                  expLast,
    input  int                                    expRemaining,
    output int                                    checkErrors
);

    initial checkErrors = 0;

    task automatic logFailure(input string text);
        checkErrors++;
        $display("%s", text);
    endtask

    ////////////////////
    // input handshake
    ////////////////////

    resetIdle: assert property (@(posedge iClock) disable iff (reset)
        $fell(reset) |-> !inAck && !outReq)
        else logFailure($sformatf("inAck or outReq high right after reset at %0t ns", $time));

    ackFollowsReq: assert property (@(posedge iClock) disable iff (reset)
        $rose(inAck) |-> $past(inReq))
        else logFailure($sformatf("inAck rose at %0t ns with no inReq pending", $time));

    wordAckTime: assert property (@(posedge iClock) disable iff (reset)
        $rose(inReq) && inOp != lpcPkg::opFrameEnd |=> inAck)
        else logFailure($sformatf("inAck late for a coefficient or error word at %0t ns",
            $time));

    // frame end ack is the back-pressure release.
    frameEndAck: assert property (@(posedge iClock) disable iff (reset)
        $rose(inAck) && inOp == lpcPkg::opFrameEnd |-> expRemaining == 0)
        else logFailure($sformatf("frame end acked at %0t ns with %0d transfers still due",
            $time, $sampled(expRemaining)));

    ////////////////////
    // output handshake
    ////////////////////

    noSpareTransfer: assert property (@(posedge iClock) disable iff (reset)
        outReq |-> expRemaining != 0)
        else logFailure($sformatf("outReq high at %0t ns with no transfer due", $time));

    outputHeld: assert property (@(posedge iClock) disable iff (reset)
        outReq && !outAck |=> outReq && $stable(outCoeff) && $stable(outIndex)
            && $stable(outOrder) && $stable(outLast))
        else logFailure($sformatf("output word changed before outAck at %0t ns", $time));

    coeffMatch: assert property (@(posedge iClock) disable iff (reset)
        outReq && outAck |-> outCoeff == expCoeff)
        else logFailure($sformatf("Mismatch at %0t ns: outCoeff got %0d expected %0d",
            $time, $sampled(outCoeff), $sampled(expCoeff)));

    indexMatch: assert property (@(posedge iClock) disable iff (reset)
        outReq && outAck |-> outIndex == expIndex)
        else logFailure($sformatf("Mismatch at %0t ns: outIndex got %0d expected %0d",
            $time, $sampled(outIndex), $sampled(expIndex)));

    orderMatch: assert property (@(posedge iClock) disable iff (reset)
        outReq && outAck |-> outOrder == expOrder)
        else logFailure($sformatf("Mismatch at %0t ns: outOrder got %0d expected %0d",
            $time, $sampled(outOrder), $sampled(expOrder)));

    lastMatch: assert property (@(posedge iClock) disable iff (reset)
        outReq && outAck |-> outLast == expLast)
        else logFailure($sformatf("Mismatch at %0t ns: outLast got %0b expected %0b",
            $time, $sampled(outLast), $sampled(expLast)));

endmodule

// ==== hdl/lpcCoeffSelect.sv ====
`timescale 1ns/1ns

module lpcCoeffSelect #(
    parameter int maxOrder     = 12,
    parameter int orderPenalty = 0
) (
    input  logic                                  iClock,
    input  logic                                  reset,
    input  logic                                  inReq,
    output logic                                  inAck,
    input  lpcPkg::lpcOp                          inOp,
    input  logic        [lpcPkg::orderWidth-1:0]  inOrder,
    input  logic signed [lpcPkg::coeffWidth-1:0]  inCoeff,
    input  logic        [lpcPkg::errorWidth-1:0]  inError,
    output logic                                  outReq,
    input  logic                                  outAck,
    output logic signed [lpcPkg::coeffWidth-1:0]  outCoeff,
    output logic        [lpcPkg::orderWidth-1:0]  outIndex,
    output logic        [lpcPkg::orderWidth-1:0]  outOrder,
    output logic                                  outLast
);

    logic                                 load;
    logic                                 unload;
    logic                                 clear;
    logic        [lpcPkg::orderWidth-1:0] order;
    logic signed [lpcPkg::coeffWidth-1:0] coeff;
    logic signed [lpcPkg::coeffWidth-1:0] storeCoeff;
    logic                                 storeValid;
    logic                                 storeDone;
    logic                                 update;
    logic                                 frameClear;
    logic        [lpcPkg::errorWidth-1:0] error;
    logic        [lpcPkg::orderWidth-1:0] bestOrder;
    logic                                 anyOrder;

    lpcOrderController #(.maxOrder(maxOrder)) lpcOrderController_i (.*);

    durbinCoefficientStore #(.maxOrder(maxOrder)) durbinCoefficientStore_i (
        .iClock, .reset, .load, .unload, .clear, .order, .coeff,
        .storeCoeff, .storeValid, .storeDone
    );

    // order line is shared with the store.
    bestOrderSelector #(
        .maxOrder    (maxOrder),
        .orderPenalty(orderPenalty)
    ) bestOrderSelector_i (
        .iClock, .reset, .update, .frameClear, .order, .error,
        .bestOrder, .anyOrder
    );

endmodule

// ==== hdl/lpcOrderController.sv ====
`timescale 1ns/1ns

module lpcOrderController #(
    parameter int maxOrder = 12
) (
    input  logic                                  iClock,
    input  logic                                  reset,
    // producer side.
    input  logic                                  inReq,
    output logic                                  inAck,
    input  lpcPkg::lpcOp                          inOp,
    input  logic        [lpcPkg::orderWidth-1:0]  inOrder,
    input  logic signed [lpcPkg::coeffWidth-1:0]  inCoeff,
    input  logic        [lpcPkg::errorWidth-1:0]  inError,
    // consumer side.
    output logic                                  outReq,
    input  logic                                  outAck,
    output logic signed [lpcPkg::coeffWidth-1:0]  outCoeff,
    output logic        [lpcPkg::orderWidth-1:0]  outIndex,
    output logic        [lpcPkg::orderWidth-1:0]  outOrder,
    output logic                                  outLast,
    // store.
    output logic                                  load,
    output logic                                  unload,
    output logic                                  clear,
    output logic        [lpcPkg::orderWidth-1:0]  order,
    output logic signed [lpcPkg::coeffWidth-1:0]  coeff,
    input  logic signed [lpcPkg::coeffWidth-1:0]  storeCoeff,
    input  logic                                  storeValid,
    input  logic                                  storeDone,
    // selector.
    output logic                                  update,
    output logic                                  frameClear,
    output logic        [lpcPkg::errorWidth-1:0]  error,
    input  logic        [lpcPkg::orderWidth-1:0]  bestOrder,
    input  logic                                  anyOrder
);

    lpcPkg::ctrlState state;
    logic             lastIndex;

    assign unload     = (state == lpcPkg::stUnload);
    assign clear      = (state == lpcPkg::stFinish);
    assign frameClear = (state == lpcPkg::stFinish);
    assign lastIndex  = outLast || (outIndex == lpcPkg::orderWidth'(maxOrder - 1));

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge iClock) begin
        if (reset) begin
            state    <= lpcPkg::stIdle;
            inAck    <= 1'b0;
            outReq   <= 1'b0;
            outLast  <= 1'b0;
            outIndex <= '0;
            load     <= 1'b0;
            update   <= 1'b0;
        end else begin
            load   <= 1'b0;
            update <= 1'b0;
            case (state)
                lpcPkg::stIdle: begin
                    if (inReq) begin
                        inAck <= 1'b1;
                        state <= lpcPkg::stAckIn;
                        case (inOp)
                            lpcPkg::opCoeff: load <= 1'b1;
                            lpcPkg::opError: update <= 1'b1;
                            lpcPkg::opFrameEnd: begin
                                outIndex <= '0;
                                if (anyOrder && bestOrder <= maxOrder) begin
                                    inAck <= 1'b0; // held until the last transfer.
                                    state <= lpcPkg::stUnload;
                                end else begin
                                    state <= lpcPkg::stFinish; // empty frame.
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                lpcPkg::stUnload: state <= lpcPkg::stWait;
                lpcPkg::stWait: begin
                    if (storeValid) begin
                        outLast <= storeDone;
                        state   <= lpcPkg::stOutReq;
                    end else begin
                        inAck <= 1'b1;
                        state <= lpcPkg::stFinish;
                    end
                end
                lpcPkg::stOutReq: begin
                    outReq <= 1'b1;
                    if (outReq && outAck) begin
                        outReq <= 1'b0;
                        state  <= lpcPkg::stOutDrop;
                    end
                end
                lpcPkg::stOutDrop: begin
                    if (!outAck) begin
                        if (lastIndex) begin
                            inAck <= 1'b1;
                            state <= lpcPkg::stFinish;
                        end else begin
                            outIndex <= outIndex + 1'b1;
                            state    <= lpcPkg::stUnload;
                        end
                    end
                end
                lpcPkg::stFinish: state <= lpcPkg::stAckIn;
                lpcPkg::stAckIn: begin
                    if (!inReq) begin
                        inAck <= 1'b0;
                        state <= lpcPkg::stIdle;
                    end
                end
                default: state <= lpcPkg::stIdle;
            endcase
        end
    end

    ////////////////////
    // data registers
    ////////////////////

    always_ff @(posedge iClock) begin
        if (state == lpcPkg::stIdle && inReq) begin
            coeff <= inCoeff;
            error <= inError;
            order <= (inOp == lpcPkg::opFrameEnd) ? bestOrder : inOrder;
        end
        if (state == lpcPkg::stWait && storeValid) begin
            outCoeff <= storeCoeff;
            outOrder <= order;
        end
    end

    outReqHeld: assert property (
        @(posedge iClock) disable iff (reset)
        outReq && !outAck |=> outReq && $stable(outCoeff) && $stable(outIndex)
            && $stable(outOrder) && $stable(outLast)
    );

endmodule

// ==== hdl/bestOrderSelector.sv ====
`timescale 1ns/1ns

module bestOrderSelector #(
    parameter int maxOrder     = 12,
    parameter int orderPenalty = 0
) (
    input  logic                           iClock,
    input  logic                           reset,
    input  logic                           update,
    input  logic                           frameClear,
    input  logic [lpcPkg::orderWidth-1:0]  order,
    input  logic [lpcPkg::errorWidth-1:0]  error,
    output logic [lpcPkg::orderWidth-1:0]  bestOrder,
    output logic                           anyOrder
);

    localparam int wideWidth = lpcPkg::errorWidth + 1;

    logic [wideWidth-1:0]          penaltyTerm;
    logic [wideWidth-1:0]          costWide;
    logic [lpcPkg::errorWidth-1:0] cost;
    logic [lpcPkg::errorWidth-1:0] bestCost;
    logic                          validOrder;

    ////////////////////
    // cost
    ////////////////////

    assign penaltyTerm = wideWidth'(order) * wideWidth'(orderPenalty);
    assign costWide    = {1'b0, error} + penaltyTerm;
    assign cost        = costWide[wideWidth-1] ? '1 : costWide[lpcPkg::errorWidth-1:0];

    assign validOrder  = (order != '0) && (order <= maxOrder);

    ////////////////////
    // running minimum
    ////////////////////

    always_ff @(posedge iClock) begin
        if (reset) begin
            bestOrder <= '0;
            anyOrder  <= 1'b0;
        end else if (frameClear) begin
            bestOrder <= '0;
            anyOrder  <= 1'b0;
        end else if (update && validOrder) begin
            // strict compare keeps the lower order on a tie.
            if (!anyOrder || cost < bestCost) begin
                bestOrder <= order;
                anyOrder  <= 1'b1;
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (update && validOrder && (!anyOrder || cost < bestCost)) begin
            bestCost <= cost;
        end
    end

    bestOrderSet: assert property (
        @(posedge iClock) disable iff (reset)
        anyOrder |-> bestOrder != '0
    );

endmodule

// ==== hdl/durbinCoefficientStore.sv ====
`timescale 1ns/1ns

module durbinCoefficientStore #(
    parameter int maxOrder = 12
) (
    input  logic                                  iClock,
    input  logic                                  reset,
    input  logic                                  load,
    input  logic                                  unload,
    input  logic                                  clear,
    input  logic        [lpcPkg::orderWidth-1:0]  order,
    input  logic signed [lpcPkg::coeffWidth-1:0]  coeff,
    output logic signed [lpcPkg::coeffWidth-1:0]  storeCoeff,
    output logic                                  storeValid,
    output logic                                  storeDone
);

    ////////////////////
    // per-order registers
    ////////////////////

    // oldest entry of each order's shift register.
    logic signed [lpcPkg::coeffWidth-1:0] tailCoeff [1:maxOrder];

    logic [lpcPkg::orderWidth-1:0] unloadCount;
    logic                          unloadShift;

    // no shifting once the whole order has been read out.
    assign unloadShift = unload && !storeDone;

    for (genvar m = 1; m <= maxOrder; m++) begin : orderReg
        logic signed [lpcPkg::coeffWidth-1:0] taps [m];
        logic                                 selected;

        assign selected = (order == lpcPkg::orderWidth'(m));

        always_ff @(posedge iClock) begin
            if (load && selected) begin
                for (int i = m - 1; i > 0; i--) begin
                    taps[i] <= taps[i-1];
                end
                taps[0] <= coeff; // newest enters at the head.
            end else if (unloadShift && selected) begin
                for (int i = m - 1; i > 0; i--) begin
                    taps[i] <= taps[i-1];
                end
            end
        end

        assign tailCoeff[m] = taps[m-1];
    end

    ////////////////////
    // unload and done
    ////////////////////

    always_ff @(posedge iClock) begin
        if (reset) begin
            storeValid  <= 1'b0;
            storeDone   <= 1'b0;
            unloadCount <= '0;
        end else begin
            storeValid <= 1'b0;
            if (clear) begin
                storeDone   <= 1'b0;
                unloadCount <= '0;
            end else if (unloadShift) begin
                storeValid  <= 1'b1;
                unloadCount <= unloadCount + 1'b1;
                if (unloadCount == order - 1'b1) begin
                    storeDone <= 1'b1; // m-th entry goes out now.
                end
            end
        end
    end

    // output word.
    always_ff @(posedge iClock) begin
        if (unloadShift) begin
            storeCoeff <= tailCoeff[order];
        end
    end

    ////////////////////
    // checks
    ////////////////////

    loadUnloadExclusive: assert property (
        @(posedge iClock) disable iff (reset)
        !(load && unload)
    );

    orderInRange: assert property (
        @(posedge iClock) disable iff (reset)
        (load || unload) |-> (order >= 1 && order <= maxOrder)
    );

endmodule

// ==== hdl/lpcPkg.sv ====
package lpcPkg;

    ////////////////////
    // data widths
    ////////////////////

    localparam int coeffWidth = 15; // signed quantized coefficient.
    localparam int errorWidth = 32; // unsigned error estimate.
    localparam int orderWidth = 4;

    ////////////////////
    // input word kinds
    ////////////////////

    typedef enum logic [1:0] {
        opCoeff    = 2'd0,
        opError    = 2'd1,
        opFrameEnd = 2'd2
    } lpcOp;

    ////////////////////
    // controller states
    ////////////////////

    typedef enum logic [2:0] {
        stIdle    = 3'd0,
        stAckIn   = 3'd1, // wait for inReq to drop.
        stUnload  = 3'd2,
        stWait    = 3'd3,
        stOutReq  = 3'd4,
        stOutDrop = 3'd5,
        stFinish  = 3'd6  // frame end ack and clear.
    } ctrlState;

endpackage
